//--- list.f
hw/soc_map_pkg.sv
hw/dbg_pkg.sv
hw/wb_addr_decode.sv
hw/boot_rom.sv
hw/clint_timer.sv
hw/dmi_debug_unit.sv
hw/soc_subsystem.sv
test/tb_soc_subsystem_asserts.sv
test/tb_soc_subsystem.sv

//--- run.sh
#!/bin/sh
# Build with Verilator and run; success only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wall -Wno-fatal \
  --top-module tb_soc_subsystem -f list.f -o sim_soc &&
./obj_dir/sim_soc | tee /dev/stderr | grep -q "Testbench passed" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

//--- test/tb_soc_subsystem.sv
module tb_soc_subsystem
  import soc_map_pkg::*;
  import dbg_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned Delay = 64;
  localparam int unsigned MaxCycles = 4000;

  logic clk_i = 1'b0;
  logic rst_ni = 1'b0;
  logic rtc_i = 1'b0;
  logic wb_cyc_i = 1'b0;
  logic wb_stb_i = 1'b0;
  logic wb_we_i = 1'b0;
  logic [AddrWidth-1:0] wb_adr_i = '0;
  logic [DataWidth-1:0] wb_dat_i = '0;
  logic [SelWidth-1:0] wb_sel_i = '0;
  logic [DataWidth-1:0] wb_dat_o;
  logic wb_ack_o;
  logic wb_err_o;
  logic dmi_req_valid_i = 1'b0;
  logic dmi_req_ready_o;
  logic dmi_resp_valid_o;
  logic dmi_resp_ready_i = 1'b1;
  logic [DmiAddrWidth-1:0] dmi_req_addr_i = '0;
  dmi_op_e dmi_req_op_i = DmiNop;
  logic [DmiDataWidth-1:0] dmi_req_data_i = '0;
  dmi_resp_e dmi_resp_resp_o;
  logic [DmiDataWidth-1:0] dmi_resp_data_o;
  logic debug_req_o;
  logic ndmreset_o;
  logic timer_irq_o;
  logic ipi_o;

  // Testbench models and expectation queues
  int unsigned cycles = 0;
  int unsigned rel_cycles = 0;
  int unsigned rtc_edges = 0;
  logic [15:0] lfsr = 16'd37127;
  logic [31:0] ctrl_model = '0;
  logic [63:0] mtime_model = '0;
  logic [63:0] cmp_model = '1;
  logic exp_err_q[$];
  logic exp_chk_q[$];
  logic [DataWidth-1:0] exp_dat_q[$];
  dmi_resp_e exp_resp_q[$];
  logic [DmiDataWidth-1:0] exp_rdata_q[$];
  logic resp_prev = 1'b0;

  soc_subsystem #(.DelayCycles(Delay)) uut (.*);

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (rst_ni) rel_cycles <= rel_cycles + 1;
    if (cycles >= MaxCycles) begin
      $display("Run did not finish within %0d cycles", MaxCycles);
      $display("Testbench failed");
      $fatal(1);
    end
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) stop_with_error($sformatf("FAIL %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_resp(input string name, input dmi_resp_e got, input dmi_resp_e exp);
    if (got !== exp) stop_with_error($sformatf("FAIL %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) stop_with_error($sformatf("FAIL %s got %h expected %h", name, got, exp));
  endtask

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] next_random();
    logic [31:0] val;
    for (int i = 0; i < 32; i++) begin
      val[i] = lfsr[0];
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return val;
  endfunction

  // --------------------
  // Reference functions
  // --------------------
  function automatic logic [31:0] rom_ref(input int unsigned idx);
    return (idx < BootWords) ? BootImage[idx] : 32'h0;
  endfunction

  function automatic logic irq_ref(input logic [63:0] mtime, input logic [63:0] cmp);
    return mtime >= cmp;
  endfunction

  function automatic logic [33:0] dmi_ref(input dmi_op_e op, input logic [6:0] addr,
                                          input logic [31:0] ctrl);
    if (op == DmiNop) return {DmiSuccess, 32'h0};
    if (addr != DmControlAddr) return {DmiFailed, 32'h0};
    return {DmiSuccess, (op == DmiRead) ? ctrl : 32'h0};
  endfunction

  // Compare process samples between rising edges
  always @(negedge clk_i) begin
    if (rst_ni && (wb_ack_o || wb_err_o)) begin
      if (exp_err_q.size() == 0) stop_with_error("Bus response without a pending access");
      check_bit("wb_err_o", wb_err_o, exp_err_q[0]);
      check_bit("wb_ack_o", wb_ack_o, !exp_err_q[0]);
      if (exp_chk_q[0]) check_word("wb_dat_o", wb_dat_o, exp_dat_q[0]);
      void'(exp_err_q.pop_front());
      void'(exp_chk_q.pop_front());
      void'(exp_dat_q.pop_front());
    end
    if (rst_ni && dmi_resp_valid_o && !resp_prev) begin
      if (exp_resp_q.size() == 0) stop_with_error("DMI response without a request");
      check_resp("dmi_resp_resp_o", dmi_resp_resp_o, exp_resp_q.pop_front());
      check_word("dmi_resp_data_o", dmi_resp_data_o, exp_rdata_q.pop_front());
    end
    resp_prev = dmi_resp_valid_o;
  end

  task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                            input logic exp_err, input logic chk, input logic [31:0] exp);
    exp_err_q.push_back(exp_err);
    exp_chk_q.push_back(chk);
    exp_dat_q.push_back(exp);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    wb_sel_i = '1;
    // Every access answers one cycle after the strobe is seen
    @(negedge clk_i);
    if (!wb_ack_o && !wb_err_o) begin
      stop_with_error("No ack or err one cycle after the strobe");
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    @(negedge clk_i);
    check_bit("wb_ack_o", wb_ack_o, 1'b0);
    check_bit("wb_err_o", wb_err_o, 1'b0);
  endtask

  task automatic dmi_request(input dmi_op_e op, input logic [6:0] addr, input logic [31:0] dat);
    logic [33:0] exp;
    exp = dmi_ref(op, addr, ctrl_model);
    exp_resp_q.push_back(dmi_resp_e'(exp[33:32]));
    exp_rdata_q.push_back(exp[31:0]);
    dmi_req_valid_i = 1'b1;
    dmi_req_op_i    = op;
    dmi_req_addr_i  = addr;
    dmi_req_data_i  = dat;
    do @(negedge clk_i); while (!dmi_resp_valid_o);
    dmi_req_valid_i = 1'b0;
    if (op == DmiWrite && addr == DmControlAddr) ctrl_model = dat;
  endtask

  // Read both mtime halves and compare with the edge count
  task automatic read_mtime();
    bus_access(1'b0, ClintBase + ClintMtimeOff, '0, 1'b0, 1'b1, mtime_model[31:0]);
    bus_access(1'b0, ClintBase + ClintMtimeOff + 4, '0, 1'b0, 1'b1, mtime_model[63:32]);
  endtask

  initial begin
    logic [31:0] rnd;
    logic [31:0] held_data;
    dmi_resp_e held_resp;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;

    // Halt request gated until the hold-off ends
    dmi_request(DmiWrite, DmControlAddr, 32'h8000_0001);
    while (rel_cycles < Delay + 6) begin
      check_bit("debug_req_o", debug_req_o,
                ctrl_model[HaltReqBit] & ctrl_model[DmActiveBit] & (rel_cycles >= Delay));
      @(negedge clk_i);
    end
    dmi_request(DmiWrite, DmControlAddr, 32'h0000_0001);
    check_bit("debug_req_o", debug_req_o, 1'b0);
    dmi_request(DmiRead, DmControlAddr, '0);
    dmi_request(DmiRead, 7'h33, '0);
    dmi_request(DmiNop, 7'h10, '0);

    // --------------------
    // ROM and unmapped
    // --------------------
    for (int i = 0; i < 10; i++) begin
      bus_access(1'b0, RomBase + 4 * i, '0, 1'b0, 1'b1, rom_ref(i));
    end
    for (int i = 0; i < 8; i++) begin
      rnd = next_random();
      bus_access(rnd[0], rnd | 32'h8000_0000, rnd, 1'b1, 1'b0, '0);
    end

    // --------------------
    // CLINT
    // --------------------
    bus_access(1'b1, ClintBase + ClintMsipOff, 32'h1, 1'b0, 1'b0, '0);
    check_bit("ipi_o", ipi_o, 1'b1);
    bus_access(1'b1, ClintBase + ClintMsipOff, 32'h0, 1'b0, 1'b0, '0);
    check_bit("ipi_o", ipi_o, 1'b0);
    for (int i = 0; i < 5; i++) begin
      rtc_i = 1'b1;
      rtc_edges++;
      repeat (4) @(negedge clk_i);
      rtc_i = 1'b0;
      repeat (4) @(negedge clk_i);
    end
    repeat (4) @(negedge clk_i);
    mtime_model = 64'(rtc_edges);
    read_mtime();
    cmp_model = 64'd2;
    bus_access(1'b1, ClintBase + ClintMtimecmpOff, 32'h2, 1'b0, 1'b0, '0);
    bus_access(1'b1, ClintBase + ClintMtimecmpOff + 4, 32'h0, 1'b0, 1'b0, '0);
    check_bit("timer_irq_o", timer_irq_o, irq_ref(mtime_model, cmp_model));
    cmp_model = '1;
    bus_access(1'b1, ClintBase + ClintMtimecmpOff + 4, '1, 1'b0, 1'b0, '0);
    bus_access(1'b1, ClintBase + ClintMtimecmpOff, '1, 1'b0, 1'b0, '0);
    check_bit("timer_irq_o", timer_irq_o, irq_ref(mtime_model, cmp_model));

    // --------------------
    // DMI back-pressure and ndmreset
    // --------------------
    dmi_resp_ready_i = 1'b0;
    dmi_request(DmiRead, DmControlAddr, '0);
    held_resp = dmi_resp_resp_o;
    held_data = dmi_resp_data_o;
    // A waiting Nop must not disturb the held response
    dmi_req_valid_i = 1'b1;
    dmi_req_op_i    = DmiNop;
    repeat (5) begin
      @(negedge clk_i);
      check_bit("dmi_resp_valid_o", dmi_resp_valid_o, 1'b1);
      check_bit("dmi_req_ready_o", dmi_req_ready_o, 1'b0);
      check_resp("dmi_resp_resp_o", dmi_resp_resp_o, held_resp);
      check_word("dmi_resp_data_o", dmi_resp_data_o, held_data);
    end
    dmi_req_valid_i = 1'b0;
    dmi_resp_ready_i = 1'b1;
    @(negedge clk_i);
    dmi_request(DmiWrite, DmControlAddr, 32'h0000_0003);
    check_bit("ndmreset_o", ndmreset_o, 1'b1);
    @(negedge clk_i);
    mtime_model = '0;
    read_mtime();

    repeat (4) @(negedge clk_i);
    if (exp_err_q.size() != 0 || exp_resp_q.size() != 0) begin
      stop_with_error("Responses still outstanding at the end of the run");
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

//--- test/tb_soc_subsystem_asserts.sv
module tb_soc_subsystem_asserts #(
  parameter int unsigned HoldCycles = 64
) (
  input logic clk_i,
  input logic rst_ni,
  input logic wb_cyc_i,
  input logic wb_stb_i,
  input logic wb_ack_o,
  input logic wb_err_o,
  input logic dmi_resp_valid_o,
  input logic dmi_resp_ready_i,
  input logic debug_req_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // Rising edges seen since reset release, saturating
  int unsigned edges_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      edges_q <= 0;
    end else if (edges_q < HoldCycles + 1) begin
      edges_q <= edges_q + 1;
    end
  end

  // --------------------
  // Bus responses
  // --------------------
  assert property (@(posedge clk_i) disable iff (!rst_ni) !(wb_ack_o && wb_err_o))
    else $error("ack and err high together");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_ack_o || wb_err_o) |-> $past(wb_cyc_i && wb_stb_i))
    else $error("bus response without a request");

  // --------------------
  // Debug
  // --------------------
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (dmi_resp_valid_o && !dmi_resp_ready_i) |=> dmi_resp_valid_o)
    else $error("DMI response dropped before ready");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (edges_q < HoldCycles) |-> !debug_req_o)
    else $error("halt request during hold-off");

endmodule

bind soc_subsystem tb_soc_subsystem_asserts #(
  .HoldCycles ( DelayCycles )
) u_asserts (
  .clk_i            ( clk_i            ),
  .rst_ni           ( rst_ni           ),
  .wb_cyc_i         ( wb_cyc_i         ),
  .wb_stb_i         ( wb_stb_i         ),
  .wb_ack_o         ( wb_ack_o         ),
  .wb_err_o         ( wb_err_o         ),
  .dmi_resp_valid_o ( dmi_resp_valid_o ),
  .dmi_resp_ready_i ( dmi_resp_ready_i ),
  .debug_req_o      ( debug_req_o      )
);

//--- hw/soc_subsystem.sv
module soc_subsystem
  import soc_map_pkg::*;
  import dbg_pkg::*;
#(
  parameter int unsigned DelayCycles = 64
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    rtc_i,
  // Wishbone slave port
  input  logic                    wb_cyc_i,
  input  logic                    wb_stb_i,
  input  logic                    wb_we_i,
  input  logic [AddrWidth-1:0]    wb_adr_i,
  input  logic [DataWidth-1:0]    wb_dat_i,
  input  logic [SelWidth-1:0]     wb_sel_i,
  output logic [DataWidth-1:0]    wb_dat_o,
  output logic                    wb_ack_o,
  output logic                    wb_err_o,
  // DMI
  input  logic                    dmi_req_valid_i,
  output logic                    dmi_req_ready_o,
  input  logic [DmiAddrWidth-1:0] dmi_req_addr_i,
  input  dmi_op_e                 dmi_req_op_i,
  input  logic [DmiDataWidth-1:0] dmi_req_data_i,
  output logic                    dmi_resp_valid_o,
  input  logic                    dmi_resp_ready_i,
  output dmi_resp_e               dmi_resp_resp_o,
  output logic [DmiDataWidth-1:0] dmi_resp_data_o,
  // Hart side
  output logic                    debug_req_o,
  output logic                    ndmreset_o,
  output logic                    timer_irq_o,
  output logic                    ipi_o
);

  logic                 rom_stb;
  logic                 rom_ack;
  logic [DataWidth-1:0] rom_dat;
  logic                 clint_stb;
  logic                 clint_ack;
  logic [DataWidth-1:0] clint_dat;

  // --------------------
  // Bus decode
  // --------------------
  wb_addr_decode i_wb_addr_decode (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .cyc_i       ( wb_cyc_i  ),
    .stb_i       ( wb_stb_i  ),
    .adr_i       ( wb_adr_i  ),
    .rom_dat_i   ( rom_dat   ),
    .rom_ack_i   ( rom_ack   ),
    .clint_dat_i ( clint_dat ),
    .clint_ack_i ( clint_ack ),
    .rom_stb_o   ( rom_stb   ),
    .clint_stb_o ( clint_stb ),
    .dat_o       ( wb_dat_o  ),
    .ack_o       ( wb_ack_o  ),
    .err_o       ( wb_err_o  )
  );

  boot_rom i_boot_rom (
    .clk_i  ( clk_i    ),
    .rst_ni ( rst_ni   ),
    .cyc_i  ( wb_cyc_i ),
    .stb_i  ( rom_stb  ),
    .we_i   ( wb_we_i  ),
    .adr_i  ( wb_adr_i ),
    .dat_o  ( rom_dat  ),
    .ack_o  ( rom_ack  )
  );

  // CLINT is also cleared by the debug reset
  clint_timer i_clint_timer (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .ndmreset_i  ( ndmreset_o  ),
    .rtc_i       ( rtc_i       ),
    .cyc_i       ( wb_cyc_i    ),
    .stb_i       ( clint_stb   ),
    .we_i        ( wb_we_i     ),
    .adr_i       ( wb_adr_i    ),
    .dat_i       ( wb_dat_i    ),
    .sel_i       ( wb_sel_i    ),
    .dat_o       ( clint_dat   ),
    .ack_o       ( clint_ack   ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  // --------------------
  // Debug
  // --------------------
  dmi_debug_unit #(
    .DelayCycles ( DelayCycles )
  ) i_dmi_debug_unit (
    .clk_i        ( clk_i            ),
    .rst_ni       ( rst_ni           ),
    .req_valid_i  ( dmi_req_valid_i  ),
    .req_addr_i   ( dmi_req_addr_i   ),
    .req_op_i     ( dmi_req_op_i     ),
    .req_data_i   ( dmi_req_data_i   ),
    .resp_ready_i ( dmi_resp_ready_i ),
    .req_ready_o  ( dmi_req_ready_o  ),
    .resp_valid_o ( dmi_resp_valid_o ),
    .resp_o       ( dmi_resp_resp_o  ),
    .resp_data_o  ( dmi_resp_data_o  ),
    .debug_req_o  ( debug_req_o      ),
    .ndmreset_o   ( ndmreset_o       )
  );

endmodule

//--- hw/dmi_debug_unit.sv
module dmi_debug_unit
  import dbg_pkg::*;
#(
  parameter int unsigned DelayCycles = 64
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    req_valid_i,
  input  logic [DmiAddrWidth-1:0] req_addr_i,
  input  dmi_op_e                 req_op_i,
  input  logic [DmiDataWidth-1:0] req_data_i,
  input  logic                    resp_ready_i,
  output logic                    req_ready_o,
  output logic                    resp_valid_o,
  output dmi_resp_e               resp_o,
  output logic [DmiDataWidth-1:0] resp_data_o,
  output logic                    debug_req_o,
  output logic                    ndmreset_o
);

  localparam int unsigned CntWidth = $clog2(DelayCycles + 2);

  logic [CntWidth-1:0]     hold_cnt_q;
  logic                    hold_off;
  logic                    accept;
  logic                    resp_valid_q;
  dmi_resp_e               resp_q;
  logic [DmiDataWidth-1:0] resp_data_q;
  logic [DmiDataWidth-1:0] dmcontrol_q;
  dmi_resp_e               resp_d;
  logic [DmiDataWidth-1:0] resp_data_d;

  // --------------------
  // Halt request gate
  // --------------------
  // Lets boot code run before the first halt can reach the hart
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_cnt_q <= CntWidth'(DelayCycles);
    end else if (hold_cnt_q != '0) begin
      hold_cnt_q <= hold_cnt_q - 1'b1;
    end
  end

  assign hold_off = (hold_cnt_q != '0);

  // --------------------
  // DMI handshake
  // --------------------
  // No new request while a response waits
  assign req_ready_o = ~resp_valid_q;
  assign accept      = req_valid_i & req_ready_o;

  always_comb begin
    resp_d      = DmiSuccess;
    resp_data_d = '0;
    case (req_op_i)
      DmiNop: begin
        resp_d = DmiSuccess;
      end
      DmiRead: begin
        if (req_addr_i == DmControlAddr) begin
          resp_data_d = dmcontrol_q;
        end else if (req_addr_i == DmStatusAddr) begin
          resp_data_d = {{(DmiDataWidth-1){1'b0}}, hold_off};
        end else begin
          resp_d = DmiFailed;
        end
      end
      DmiWrite: begin
        // status is read-only, a write there is dropped
        if (req_addr_i != DmControlAddr && req_addr_i != DmStatusAddr) begin
          resp_d = DmiFailed;
        end
      end
      default: begin
        resp_d = DmiFailed;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_q <= 1'b0;
      dmcontrol_q  <= '0;
    end else begin
      if (accept) begin
        resp_valid_q <= 1'b1;
      end else if (resp_ready_i) begin
        resp_valid_q <= 1'b0;
      end
      if (accept && req_op_i == DmiWrite && req_addr_i == DmControlAddr) begin
        dmcontrol_q <= req_data_i;
      end
    end
  end

  // Response payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_q      <= resp_d;
      resp_data_q <= resp_data_d;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_o       = resp_q;
  assign resp_data_o  = resp_data_q;

  assign debug_req_o = dmcontrol_q[HaltReqBit] & dmcontrol_q[DmActiveBit] & ~hold_off;
  assign ndmreset_o  = dmcontrol_q[NdmResetBit] & dmcontrol_q[DmActiveBit];

endmodule

//--- hw/clint_timer.sv
module clint_timer
  import soc_map_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 ndmreset_i,
  input  logic                 rtc_i,
  input  logic                 cyc_i,
  input  logic                 stb_i,
  input  logic                 we_i,
  input  logic [AddrWidth-1:0] adr_i,
  input  logic [DataWidth-1:0] dat_i,
  input  logic [SelWidth-1:0]  sel_i,
  output logic [DataWidth-1:0] dat_o,
  output logic                 ack_o,
  output logic                 timer_irq_o,
  output logic                 ipi_o
);

  // Upper halves of the 64-bit registers
  localparam logic [15:0] MtimecmpHiOff = ClintMtimecmpOff + 16'd4;
  localparam logic [15:0] MtimeHiOff    = ClintMtimeOff + 16'd4;

  logic [1:0]           rtc_sync_q;
  logic                 rtc_prev_q;
  logic                 rtc_rise;
  logic [63:0]          mtime_q;
  logic [63:0]          mtimecmp_q;
  logic                 msip_q;
  logic                 irq_q;
  logic                 ack_q;
  logic [DataWidth-1:0] dat_q;
  logic [15:0]          reg_off;
  logic                 access;
  logic                 wr_en;

  // Merge write data into a register half by byte lane
  function automatic logic [DataWidth-1:0] apply_sel(
    input logic [DataWidth-1:0] old_val,
    input logic [DataWidth-1:0] new_val,
    input logic [SelWidth-1:0]  be
  );
    logic [DataWidth-1:0] res;
    res = old_val;
    for (int i = 0; i < SelWidth; i++) begin
      if (be[i]) begin
        res[i*8 +: 8] = new_val[i*8 +: 8];
      end
    end
    return res;
  endfunction

  // --------------------
  // RTC edge detect
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_sync_q <= '0;
      rtc_prev_q <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
    end
  end

  assign rtc_rise = rtc_sync_q[1] & ~rtc_prev_q;

  // --------------------
  // Registers
  // --------------------
  assign reg_off = {adr_i[15:2], 2'b00};
  assign access  = cyc_i & stb_i & ~ack_q;
  assign wr_en   = access & we_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
    end else if (ndmreset_i) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
    end else begin
      // A bus write to mtime wins over the tick
      if (wr_en && reg_off == ClintMtimeOff) begin
        mtime_q[31:0] <= apply_sel(mtime_q[31:0], dat_i, sel_i);
      end else if (wr_en && reg_off == MtimeHiOff) begin
        mtime_q[63:32] <= apply_sel(mtime_q[63:32], dat_i, sel_i);
      end else if (rtc_rise) begin
        mtime_q <= mtime_q + 64'd1;
      end
      if (wr_en && reg_off == ClintMtimecmpOff) begin
        mtimecmp_q[31:0] <= apply_sel(mtimecmp_q[31:0], dat_i, sel_i);
      end
      if (wr_en && reg_off == MtimecmpHiOff) begin
        mtimecmp_q[63:32] <= apply_sel(mtimecmp_q[63:32], dat_i, sel_i);
      end
      if (wr_en && reg_off == ClintMsipOff && sel_i[0]) begin
        msip_q <= dat_i[0];
      end
    end
  end

  // Ack and interrupt level
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
      irq_q <= 1'b0;
    end else begin
      ack_q <= access;
      irq_q <= (mtime_q >= mtimecmp_q);
    end
  end

  // Read data, sampled when the access starts
  always_ff @(posedge clk_i) begin
    if (access) begin
      case (reg_off)
        ClintMsipOff:     dat_q <= {{(DataWidth-1){1'b0}}, msip_q};
        ClintMtimecmpOff: dat_q <= mtimecmp_q[31:0];
        MtimecmpHiOff:    dat_q <= mtimecmp_q[63:32];
        ClintMtimeOff:    dat_q <= mtime_q[31:0];
        MtimeHiOff:       dat_q <= mtime_q[63:32];
        default:          dat_q <= '0;
      endcase
    end
  end

  assign dat_o       = dat_q;
  assign ack_o       = ack_q;
  assign timer_irq_o = irq_q;
  assign ipi_o       = msip_q;

endmodule

//--- hw/boot_rom.sv
module boot_rom
  import soc_map_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 cyc_i,
  input  logic                 stb_i,
  input  logic                 we_i,
  input  logic [AddrWidth-1:0] adr_i,
  output logic [DataWidth-1:0] dat_o,
  output logic                 ack_o
);

  // Word index covering the whole ROM region
  localparam int unsigned IdxWidth = $clog2(RomLength / SelWidth);

  logic [IdxWidth-1:0]  word_idx;
  logic                 access;
  logic                 ack_q;
  logic [DataWidth-1:0] dat_q;

  assign word_idx = adr_i[IdxWidth+1:2];
  assign access   = cyc_i & stb_i & ~ack_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // Writes are acked but leave the image alone
  always_ff @(posedge clk_i) begin
    if (access) begin
      if (!we_i && (word_idx < IdxWidth'(BootWords))) begin
        dat_q <= BootImage[word_idx];
      end else begin
        dat_q <= '0;
      end
    end
  end

  assign dat_o = dat_q;
  assign ack_o = ack_q;

endmodule

//--- hw/wb_addr_decode.sv
module wb_addr_decode
  import soc_map_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 cyc_i,
  input  logic                 stb_i,
  input  logic [AddrWidth-1:0] adr_i,
  input  logic [DataWidth-1:0] rom_dat_i,
  input  logic                 rom_ack_i,
  input  logic [DataWidth-1:0] clint_dat_i,
  input  logic                 clint_ack_i,
  output logic                 rom_stb_o,
  output logic                 clint_stb_o,
  output logic [DataWidth-1:0] dat_o,
  output logic                 ack_o,
  output logic                 err_o
);

  slave_sel_e sel;
  logic       err_q;

  // --------------------
  // Region compare
  // --------------------
  always_comb begin
    if ((adr_i >= RomBase) && (adr_i < RomBase + RomLength)) begin
      sel = SlvRom;
    end else if ((adr_i >= ClintBase) && (adr_i < ClintBase + ClintLength)) begin
      sel = SlvClint;
    end else begin
      sel = SlvNone;
    end
  end

  // Only the selected slave sees the strobe
  assign rom_stb_o   = cyc_i & stb_i & (sel == SlvRom);
  assign clint_stb_o = cyc_i & stb_i & (sel == SlvClint);

  // --------------------
  // Response path
  // --------------------
  // Master holds the address through the ack cycle, so sel is still valid
  always_comb begin
    case (sel)
      SlvRom: begin
        dat_o = rom_dat_i;
        ack_o = rom_ack_i;
      end
      SlvClint: begin
        dat_o = clint_dat_i;
        ack_o = clint_ack_i;
      end
      default: begin
        dat_o = '0;
        ack_o = 1'b0;
      end
    endcase
  end

  // Error responder for unmapped accesses, one pulse per access
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_q <= 1'b0;
    end else begin
      err_q <= cyc_i & stb_i & (sel == SlvNone) & ~err_q;
    end
  end

  assign err_o = err_q;

endmodule

//--- hw/dbg_pkg.sv
package dbg_pkg;

  // DMI field widths
  localparam int unsigned DmiAddrWidth = 7;
  localparam int unsigned DmiDataWidth = 32;

  typedef enum logic [1:0] {
    DmiNop   = 2'h0,
    DmiRead  = 2'h1,
    DmiWrite = 2'h2
  } dmi_op_e;

  typedef enum logic [1:0] {
    DmiSuccess = 2'h0,
    DmiFailed  = 2'h2,
    DmiBusy    = 2'h3
  } dmi_resp_e;

  // Debug register addresses
  localparam logic [DmiAddrWidth-1:0] DmControlAddr = 7'h10;
  localparam logic [DmiAddrWidth-1:0] DmStatusAddr  = 7'h11;

  // Bit positions in dmcontrol
  localparam int unsigned DmActiveBit = 0;
  localparam int unsigned NdmResetBit = 1;
  localparam int unsigned HaltReqBit  = 31;

endpackage

//--- hw/soc_map_pkg.sv
package soc_map_pkg;

  // Wishbone bus widths
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned SelWidth  = DataWidth / 8;

  // --------------------
  // Address map
  // --------------------
  localparam logic [AddrWidth-1:0] RomBase     = 32'h0001_0000;
  localparam logic [AddrWidth-1:0] RomLength   = 32'h0000_1000;
  localparam logic [AddrWidth-1:0] ClintBase   = 32'h0200_0000;
  localparam logic [AddrWidth-1:0] ClintLength = 32'h0001_0000;

  typedef enum logic [1:0] {
    SlvRom,
    SlvClint,
    SlvNone
  } slave_sel_e;

  // CLINT register offsets inside its region
  localparam logic [15:0] ClintMsipOff     = 16'h0000;
  localparam logic [15:0] ClintMtimecmpOff = 16'h4000;
  localparam logic [15:0] ClintMtimeOff    = 16'hBFF8;

  // --------------------
  // Boot image
  // --------------------
  localparam int unsigned BootWords = 8;

  localparam logic [0:BootWords-1][DataWidth-1:0] BootImage = '{
    32'hf140_2573, 32'h0200_02b7, 32'h0010_0313, 32'h0062_a023,
    32'h0000_0597, 32'h1050_0073, 32'h0000_8067, 32'hffdf_f06f
  };

endpackage
